//--- logic/rv_consts.svh
//////////////////////////////
// rv32i core constants
// widths, reset pc, opcodes, funct codes
//////////////////////////////
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN       32
`define REG_ADDR_W 5
`define NUM_REGS   32
`define RESET_PC   32'h8000_0000

// major opcodes
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F3_ADD  3'b000 // also sub
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101 // srl / sra
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F7_ALT  7'b0100000 // sub, sra

`endif

//--- logic/rv_pkg.sv
//////////////////////////////
// rv32i shared types
// formats, alu ops, instruction word views
//////////////////////////////
`include "rv_consts.svh"

package rv_pkg;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_U,
        FMT_J,
        FMT_B,
        FMT_NONE
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]            imm20;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    // branch offset is scattered around rs1/rs2
    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t           r_fmt;
        i_fmt_t           i_fmt;
        u_fmt_t           u_fmt;
        b_fmt_t           b_fmt;
        j_fmt_t           j_fmt;
        logic [`XLEN-1:0] raw;
    } inst_word_u;

endpackage

//--- logic/fetch_unit.sv
//////////////////////////////
// fetch sequencer
// pc, instruction register, fetch/wait/exec
//////////////////////////////
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               imem_valid,
    input  logic [`XLEN-1:0]   imem_rdata,
    input  logic [`XLEN-1:0]   next_pc,
    output logic               imem_req,
    output logic [`XLEN-1:0]   imem_addr,
    output logic [`XLEN-1:0]   pc,
    output rv_pkg::inst_word_u inst,
    output logic               exec
);
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_WAIT,
        ST_EXEC
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        unique case (state)
            ST_FETCH: state_next = ST_WAIT;
            ST_WAIT:  state_next = imem_valid ? ST_EXEC : ST_WAIT;
            ST_EXEC:  state_next = ST_FETCH;
            default:  state_next = ST_FETCH;
        endcase
    end

    // reset parks in EXEC with exec low, so the first edge goes to FETCH
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_EXEC;
            exec  <= 1'b0;
            pc    <= `RESET_PC;
        end else begin
            state <= state_next;
            exec  <= (state == ST_WAIT) && imem_valid; // retire the cycle after the strobe
            if (exec) pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT && imem_valid) inst.raw <= imem_rdata;
    end

    assign imem_req  = (state == ST_FETCH); // single-cycle pulse
    assign imem_addr = pc;

    // memory may only answer an outstanding request
    a_valid_in_wait: assert property (@(posedge clk) disable iff (reset)
        imem_valid |-> state == ST_WAIT)
        else $error("imem_valid outside of WAIT");

    a_exec_then_req: assert property (@(posedge clk) disable iff (reset)
        exec |=> imem_req)
        else $error("no fetch after retire");

endmodule

//--- logic/decoder.sv
//////////////////////////////
// instruction decoder
// format, immediate and alu op
//////////////////////////////
`timescale 1ns/1ps
`include "rv_consts.svh"

module decoder (
    input  rv_pkg::inst_word_u     inst,
    output rv_pkg::inst_fmt_t      fmt,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [2:0]             funct3,
    output logic [`XLEN-1:0]       imm,
    output rv_pkg::alu_op_t        alu_op
);
    logic [6:0] opcode;
    logic [6:0] funct7;

    // register fields sit at the same place in every format
    assign opcode = inst.r_fmt.opcode;
    assign funct7 = inst.r_fmt.funct7;
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;
    assign rd     = inst.r_fmt.rd;
    assign funct3 = inst.r_fmt.funct3;

    always_comb begin
        unique case (opcode)
            `OP_REG:             fmt = rv_pkg::FMT_R;
            `OP_IMM, `OP_JALR:   fmt = rv_pkg::FMT_I;
            `OP_LUI, `OP_AUIPC:  fmt = rv_pkg::FMT_U;
            `OP_JAL:             fmt = rv_pkg::FMT_J;
            `OP_BRANCH:          fmt = rv_pkg::FMT_B;
            default:             fmt = rv_pkg::FMT_NONE; // retires as a no-op
        endcase
    end

    always_comb begin
        unique case (fmt)
            rv_pkg::FMT_I:
                imm = {{(`XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
            rv_pkg::FMT_B:
                imm = {{(`XLEN-13){inst.b_fmt.imm12}}, inst.b_fmt.imm12,
                       inst.b_fmt.imm11, inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
            rv_pkg::FMT_J:
                imm = {{(`XLEN-21){inst.j_fmt.imm20}}, inst.j_fmt.imm20,
                       inst.j_fmt.imm19_12, inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
            rv_pkg::FMT_U:
                imm = {inst.u_fmt.imm20, 12'b0};
            default:
                imm = '0;
        endcase
    end

    // jumps, branches and upper immediates all add
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (opcode == `OP_REG || opcode == `OP_IMM) begin
            unique case (funct3)
                `F3_ADD: begin
                    // addi has no sub form
                    if (fmt == rv_pkg::FMT_R && funct7 == `F7_ALT) alu_op = rv_pkg::ALU_SUB;
                end
                `F3_SLL:  alu_op = rv_pkg::ALU_SLL;
                `F3_SLT:  alu_op = rv_pkg::ALU_SLT;
                `F3_SLTU: alu_op = rv_pkg::ALU_SLTU;
                `F3_XOR:  alu_op = rv_pkg::ALU_XOR;
                `F3_SR:   alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL; // imm[10] for srai
                `F3_OR:   alu_op = rv_pkg::ALU_OR;
                `F3_AND:  alu_op = rv_pkg::ALU_AND;
                default:  alu_op = rv_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

//--- logic/execute_unit.sv
//////////////////////////////
// execute and write-back
// alu, branch compare, next pc
//////////////////////////////
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_unit (
    input  logic [`XLEN-1:0]   pc,
    input  rv_pkg::inst_word_u inst,
    input  rv_pkg::inst_fmt_t  fmt,
    input  logic [2:0]         funct3,
    input  logic [`XLEN-1:0]   imm,
    input  rv_pkg::alu_op_t    alu_op,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    output logic [`XLEN-1:0]   next_pc,
    output logic               rd_we,
    output logic [`XLEN-1:0]   rd_wdata
);
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] pc_plus4;
    logic             is_jalr;
    logic             taken;

    assign pc_plus4 = pc + `XLEN'd4;
    assign shamt    = alu_b[4:0];
    assign is_jalr  = (fmt == rv_pkg::FMT_I) && (inst.r_fmt.opcode == `OP_JALR);

    always_comb begin
        unique case (fmt)
            rv_pkg::FMT_R: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            rv_pkg::FMT_I: begin
                alu_a = rs1_data;
                alu_b = imm;
            end
            rv_pkg::FMT_U: begin
                alu_a = (inst.r_fmt.opcode == `OP_LUI) ? '0 : pc; // lui vs auipc
                alu_b = imm;
            end
            rv_pkg::FMT_J, rv_pkg::FMT_B: begin // jump target
                alu_a = pc;
                alu_b = imm;
            end
            default: begin
                alu_a = '0;
                alu_b = '0;
            end
        endcase
    end

    always_comb begin
        unique case (alu_op)
            rv_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            rv_pkg::ALU_SLL:  alu_result = alu_a << shamt;
            rv_pkg::ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            rv_pkg::ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, alu_a < alu_b};
            rv_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            rv_pkg::ALU_SRL:  alu_result = alu_a >> shamt;
            rv_pkg::ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> shamt);
            rv_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            rv_pkg::ALU_AND:  alu_result = alu_a & alu_b;
            default:          alu_result = alu_a + alu_b;
        endcase
    end

    // branch compare works on the register operands, not the alu inputs
    always_comb begin
        unique case (funct3)
            `F3_BEQ:  taken = (rs1_data == rs2_data);
            `F3_BNE:  taken = (rs1_data != rs2_data);
            `F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            `F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            `F3_BLTU: taken = (rs1_data < rs2_data);
            `F3_BGEU: taken = (rs1_data >= rs2_data);
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        if (is_jalr) next_pc = {alu_result[`XLEN-1:1], 1'b0};
        else if (fmt == rv_pkg::FMT_J || (fmt == rv_pkg::FMT_B && taken)) next_pc = alu_result;
        else next_pc = pc_plus4;
    end

    always_comb begin
        if (is_jalr || fmt == rv_pkg::FMT_J) begin
            rd_we    = 1'b1;
            rd_wdata = pc_plus4; // link address
        end else if (fmt == rv_pkg::FMT_R || fmt == rv_pkg::FMT_I || fmt == rv_pkg::FMT_U) begin
            rd_we    = 1'b1;
            rd_wdata = alu_result;
        end else begin
            rd_we    = 1'b0;
            rd_wdata = '0;
        end
    end

    // a misaligned target here means a bad jalr base or branch offset upstream
    always_comb begin
        if (fmt != rv_pkg::FMT_NONE) begin
            a_next_pc_aligned: assert final (next_pc[1:0] == 2'b00)
                else $error("next_pc %h not word aligned", next_pc);
        end
    end

endmodule

//--- logic/reg_file.sv
//////////////////////////////
// general purpose registers
//////////////////////////////
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);
    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin // x0 writes are dropped
            regs[waddr] <= wdata;
        end
    end

    // x0 keeps its reset value of zero
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("x0 holds %h", regs[0]);

endmodule

//--- logic/rv_core.sv
//////////////////////////////
// rv32i multi-cycle core top
//////////////////////////////
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   imem_valid,
    input  logic [`XLEN-1:0]       imem_rdata,
    output logic                   imem_req,
    output logic [`XLEN-1:0]       imem_addr,
    output logic                   retire_valid,
    output logic [`XLEN-1:0]       retire_pc,
    output logic                   retire_we,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic [`XLEN-1:0]       retire_wdata
);
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       next_pc;
    rv_pkg::inst_word_u     inst;
    logic                   exec;
    rv_pkg::inst_fmt_t      fmt;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic [`XLEN-1:0]       imm;
    rv_pkg::alu_op_t        alu_op;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   rd_we;
    logic [`XLEN-1:0]       rd_wdata;

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .next_pc    (next_pc),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .pc         (pc),
        .inst       (inst),
        .exec       (exec)
    );

    decoder u_decode (
        .inst   (inst),
        .fmt    (fmt),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .funct3 (funct3),
        .imm    (imm),
        .alu_op (alu_op)
    );

    // write lands at the end of EXEC
    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (exec && rd_we),
        .waddr  (rd),
        .wdata  (rd_wdata),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute_unit u_exec (
        .pc       (pc),
        .inst     (inst),
        .fmt      (fmt),
        .funct3   (funct3),
        .imm      (imm),
        .alu_op   (alu_op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .next_pc  (next_pc),
        .rd_we    (rd_we),
        .rd_wdata (rd_wdata)
    );

    assign retire_valid = exec;
    assign retire_pc    = pc;
    assign retire_we    = rd_we; // raw strobe, high for x0 too
    assign retire_rd    = rd;
    assign retire_wdata = rd_wdata;

endmodule

//--- bench/retire_checker.sv
//////////////////////////////
// retire checker
// fetch and trace ports against the table
//////////////////////////////
`timescale 1ns/1ps
`include "rv_consts.svh"

module retire_checker #(
    parameter int N = 1
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   imem_req,
    input  logic [`XLEN-1:0]       imem_addr,
    input  logic                   imem_valid,
    input  logic                   retire_valid,
    input  logic [`XLEN-1:0]       retire_pc,
    input  logic                   retire_we,
    input  logic [`REG_ADDR_W-1:0] retire_rd,
    input  logic [`XLEN-1:0]       retire_wdata,
    input  logic [`XLEN-1:0]       t_pc [N],
    input  logic                   t_we [N],
    input  logic [`REG_ADDR_W-1:0] t_rd [N],
    input  logic [`XLEN-1:0]       t_wdata [N],
    input  logic [`XLEN-1:0]       t_next [N],
    output logic                   done,
    output int                     errors
);
    int   n_fetch     = 0;
    int   n_ret       = 0;
    int   n_clean     = 0;
    int   err_count   = 0;
    int   ent_err [N] = '{default: 0};
    logic finished    = 1'b0;
    logic prev_valid  = 1'b0;
    logic prev_retire = 1'b0;

    assign done   = finished;
    assign errors = err_count;

    task automatic compare_field(input string what, input int idx, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: entry %0d %s is %h, expected %h",
                     $time, idx, what, got, exp);
            err_count++;
            ent_err[idx]++;
        end
    endtask

    task automatic protocol_fault(input int idx, input string msg);
        $display("%s at %0d ns", msg, $time);
        err_count++;
        if (idx >= 0 && idx < N) ent_err[idx]++;
    endtask

    task automatic verify_retire();
        if (n_ret >= N) begin
            protocol_fault(-1, "retire seen after the last table entry");
            return;
        end
        compare_field("retire_pc", n_ret, retire_pc, t_pc[n_ret]);
        compare_field("retire_we", n_ret, 32'(retire_we), 32'(t_we[n_ret]));
        if (t_we[n_ret]) begin // rd field is raw bits when nothing is written
            compare_field("retire_rd", n_ret, 32'(retire_rd), 32'(t_rd[n_ret]));
            compare_field("retire_wdata", n_ret, retire_wdata, t_wdata[n_ret]);
        end
        n_ret++;
    endtask

    // a fetch closes the previous entry with its next pc
    task automatic inspect_fetch();
        int k;
        k = n_fetch - 1;
        if (n_fetch > 0) begin
            if (!prev_retire) protocol_fault(k, "fetch did not come one cycle after a retire");
            compare_field("next pc", k, imem_addr, t_next[k]);
            if (ent_err[k] == 0) begin
                n_clean++;
                $display("entry %0d at %h: ok", k, t_pc[k]);
            end else begin
                $display("entry %0d at %h: mismatch", k, t_pc[k]);
            end
        end
        if (n_fetch < N) begin
            compare_field("fetch address", n_fetch, imem_addr, t_pc[n_fetch]);
        end else begin
            $display("checked %0d entries: %0d clean, %0d with errors, %0d errors in total",
                     N, n_clean, N - n_clean, err_count);
            finished = 1'b1;
        end
        n_fetch++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (imem_req || retire_valid) begin
                protocol_fault(-1, "imem_req or retire_valid high during reset");
            end
            prev_valid  = 1'b0;
            prev_retire = 1'b0;
        end else if (!finished) begin
            if (retire_valid && !prev_valid) begin
                protocol_fault(n_ret, "retire without an instruction strobe one cycle before");
            end
            if (prev_valid && !retire_valid) begin
                protocol_fault(n_ret, "instruction strobe not followed by a retire");
            end
            if (retire_valid) verify_retire();
            if (imem_req) inspect_fetch();
            prev_valid  = imem_valid;
            prev_retire = retire_valid;
        end
    end

endmodule

//--- bench/rv_core_tb.sv
//////////////////////////////
// rv32i core testbench
// table-driven program, random fetch latency
//////////////////////////////
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;
    localparam int N      = 36;
    localparam int PERIOD = 20;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   imem_valid;
    logic [`XLEN-1:0]       imem_rdata;
    logic                   imem_req;
    logic [`XLEN-1:0]       imem_addr;
    logic                   retire_valid;
    logic [`XLEN-1:0]       retire_pc;
    logic                   retire_we;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_wdata;
    logic                   done;
    int                     errors;

    // one row per retired instruction in execution order
    logic [`XLEN-1:0]       t_pc [N];
    logic [`XLEN-1:0]       t_word [N];
    logic                   t_we [N];
    logic [`REG_ADDR_W-1:0] t_rd [N];
    logic [`XLEN-1:0]       t_wdata [N];
    logic [`XLEN-1:0]       t_next [N];
    int                     n_rows = 0;

    always #(PERIOD/2) clk = ~clk;

    rv_core u_rv_core (.*);

    retire_checker #(.N(N)) u_checker (.*);

    // small assembler with the field layout of the isa manual
    function automatic logic [31:0] r_word(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {(alt ? `F7_ALT : 7'd0), rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    task automatic row(input logic [31:0] off, input logic [31:0] word, input logic we,
                       input logic [4:0] rd, input logic [31:0] wdata,
                       input logic [31:0] next_off);
        t_pc[n_rows]    = `RESET_PC + off;
        t_word[n_rows]  = word;
        t_we[n_rows]    = we;
        t_rd[n_rows]    = rd;
        t_wdata[n_rows] = wdata;
        t_next[n_rows]  = `RESET_PC + next_off;
        n_rows++;
    endtask

    task automatic load_program();
        // operands x1 = 5 and x2 = -3
        row('h00, i_word(`OP_IMM, `F3_ADD, 5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 32'd5, 'h04);
        row('h04, i_word(`OP_IMM, `F3_ADD, 5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, 32'hffff_fffd, 'h08);
        row('h08, r_word(`F3_ADD, 1'b0, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'd2, 'h0c);
        row('h0c, r_word(`F3_ADD, 1'b1, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, 32'd8, 'h10);
        row('h10, r_word(`F3_SLL, 1'b0, 5'd5, 5'd1, 5'd1), 1'b1, 5'd5, 32'h0000_00a0, 'h14);
        row('h14, r_word(`F3_SLT, 1'b0, 5'd6, 5'd2, 5'd1), 1'b1, 5'd6, 32'd1, 'h18);
        row('h18, r_word(`F3_SLTU, 1'b0, 5'd7, 5'd2, 5'd1), 1'b1, 5'd7, 32'd0, 'h1c);
        row('h1c, r_word(`F3_XOR, 1'b0, 5'd8, 5'd1, 5'd2), 1'b1, 5'd8, 32'hffff_fff8, 'h20);
        row('h20, r_word(`F3_SR, 1'b0, 5'd9, 5'd2, 5'd1), 1'b1, 5'd9, 32'h07ff_ffff, 'h24);
        row('h24, r_word(`F3_SR, 1'b1, 5'd10, 5'd2, 5'd1), 1'b1, 5'd10, 32'hffff_ffff, 'h28);
        row('h28, r_word(`F3_OR, 1'b0, 5'd11, 5'd1, 5'd2), 1'b1, 5'd11, 32'hffff_fffd, 'h2c);
        row('h2c, r_word(`F3_AND, 1'b0, 5'd12, 5'd1, 5'd2), 1'b1, 5'd12, 32'd5, 'h30);
        row('h30, i_word(`OP_IMM, `F3_SLT, 5'd13, 5'd2, 12'hffe), 1'b1, 5'd13, 32'd1, 'h34);
        row('h34, i_word(`OP_IMM, `F3_SR, 5'd14, 5'd2, 12'h401), 1'b1, 5'd14, 32'hffff_fffe, 'h38);
        row('h38, u_word(`OP_LUI, 5'd15, 20'h12345), 1'b1, 5'd15, 32'h1234_5000, 'h3c);
        row('h3c, u_word(`OP_AUIPC, 5'd16, 20'h00001), 1'b1, 5'd16, 32'h8000_103c, 'h40);
        // each branch taken, then not taken
        row('h40, b_word(`F3_BEQ, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0, 'h48);
        row('h48, b_word(`F3_BEQ, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0, 'h4c);
        row('h4c, b_word(`F3_BNE, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0, 'h54);
        row('h54, b_word(`F3_BNE, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0, 'h58);
        row('h58, b_word(`F3_BLT, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0, 'h60);
        row('h60, b_word(`F3_BLT, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0, 'h64);
        row('h64, b_word(`F3_BGE, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0, 'h6c);
        row('h6c, b_word(`F3_BGE, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0, 'h70);
        row('h70, b_word(`F3_BLTU, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0, 'h78);
        row('h78, b_word(`F3_BLTU, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0, 'h7c);
        row('h7c, b_word(`F3_BGEU, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0, 'h84);
        row('h84, b_word(`F3_BGEU, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0, 'h88);
        row('h88, j_word(5'd17, 21'd16), 1'b1, 5'd17, 32'h8000_008c, 'h98);
        // 0x8c + 0x21 is odd and jalr drops bit 0
        row('h98, i_word(`OP_JALR, 3'b000, 5'd18, 5'd17, 12'h021),
            1'b1, 5'd18, 32'h8000_009c, 'hac);
        row('hac, j_word(5'd0, 21'd8), 1'b1, 5'd0, 32'h8000_00b0, 'hb4);
        row('hb4, r_word(`F3_ADD, 1'b0, 5'd19, 5'd0, 5'd1), 1'b1, 5'd19, 32'd5, 'hb8);
        row('hb8, i_word(`OP_IMM, `F3_ADD, 5'd0, 5'd1, 12'd7), 1'b1, 5'd0, 32'd12, 'hbc);
        row('hbc, r_word(`F3_ADD, 1'b0, 5'd20, 5'd0, 5'd0), 1'b1, 5'd20, 32'd0, 'hc0);
        row('hc0, b_word(`F3_BNE, 5'd1, 5'd2, -13'sd64), 1'b0, 5'd0, 32'd0, 'h80); // backward
        row('h80, 32'h0000_000b, 1'b0, 5'd0, 32'd0, 'h84); // custom-0 retires as a no-op
    endtask

    initial begin : stimulus
        int unsigned lat;
        void'($urandom(32'hd5af_7f24));
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_rdata = '0;
        load_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < N; i++) begin
            @(negedge clk);
            while (!imem_req) @(negedge clk);
            lat = $urandom_range(4, 1);
            repeat (lat) @(negedge clk);
            imem_valid = 1'b1;
            imem_rdata = t_word[i];
            @(negedge clk);
            imem_valid = 1'b0;
        end
        wait (done);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // worst case is about 6 cycles per instruction
    initial begin : watchdog
        #(PERIOD * (N * 8 + 20));
        $display("timeout: the core did not get through all %0d table entries", N);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+logic
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/execute_unit.sv
logic/reg_file.sv
logic/rv_core.sv
bench/retire_checker.sv
bench/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the rv32i core testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
